// ==== fv_bank_ctrl.sv ====
// Bank controller FSM for loads, SRAM reads and edge-PE beat formatting
`timescale 1ns/100ps
`default_nettype none

module fv_bank_ctrl
    import fv_mem_pkg::*, fv_pe_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  fv_load_t         load_in,
    input  logic             pend_valid,
    input  rd_req_t          pend_req,
    input  logic [FV_BW-1:0] q,
    output sram_cmd_t        sram_cmd,
    output pe_beat_t         beat_out,
    output logic             done,
    output logic             busy
);

    localparam int HALF_BW = FV_BW / 2;

    // Flags that follow each read through the SRAM latency
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } iss_flags_t;

    bank_state_t state;
    bank_state_t state_nx;
    sram_cmd_t   cmd_nx;
    iss_flags_t  iss_nx;
    iss_flags_t  iss_s1;                   // Aligned with sram_cmd
    iss_flags_t  iss_s2;                   // Aligned with q
    pe_beat_t    beat_nx;

    logic [NUM_W-1:0] rd_left;             // Reads still to issue
    logic [NUM_W-1:0] rd_left_nx;
    logic [NUM_W:0]   num_p1;
    logic [NUM_W-1:0] req_beats;
    logic [TAG_W-1:0] tag_q;
    logic             odd_q;
    logic             start_rd;

    // ceil(N/2) beats per request
    assign num_p1    = {1'b0, pend_req.num_fv} + 1'b1;
    assign req_beats = num_p1[NUM_W:1];

    // Load has priority over a pending read
    assign start_rd = (state == st_idle) && !load_in.sos && pend_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and SRAM command
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nx   = state;
        cmd_nx     = sram_cmd;
        cmd_nx.cen = 1'b1;
        cmd_nx.wen = 1'b1;
        iss_nx     = '0;
        rd_left_nx = rd_left;
        case (state)
            st_idle: begin
                if (load_in.sos) begin
                    cmd_nx.cen = 1'b0;
                    cmd_nx.wen = 1'b0;
                    cmd_nx.a   = load_in.a;
                    cmd_nx.d   = load_in.fv_data;
                    state_nx   = load_in.eos ? st_idle : st_load; // One-word load
                end else if (pend_valid) begin
                    cmd_nx.cen   = 1'b0;
                    cmd_nx.a     = pend_req.addr;
                    iss_nx.valid = 1'b1;
                    iss_nx.first = 1'b1;
                    iss_nx.last  = (req_beats == NUM_W'(1));
                    rd_left_nx   = req_beats - 1'b1;
                    state_nx     = st_stream;
                end
            end
            st_load: begin
                cmd_nx.cen = 1'b0;
                cmd_nx.wen = 1'b0;
                cmd_nx.a   = load_in.a;
                cmd_nx.d   = load_in.fv_data;
                if (load_in.eos) begin
                    state_nx = st_idle;
                end
            end
            st_stream: begin
                if (rd_left != '0) begin
                    cmd_nx.cen   = 1'b0;
                    cmd_nx.a     = sram_cmd.a + 1'b1; // Next word
                    iss_nx.valid = 1'b1;
                    iss_nx.last  = (rd_left == NUM_W'(1));
                    rd_left_nx   = rd_left - 1'b1;
                end
                // Hold until the eos beat has left
                if (done) begin
                    state_nx = st_idle;
                end
            end
            default: state_nx = st_idle;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat formatting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        beat_nx = '0;
        if (iss_s2.valid) begin
            beat_nx.valid  = 1'b1;
            beat_nx.sos    = iss_s2.first;
            beat_nx.eos    = iss_s2.last;
            beat_nx.pe_tag = tag_q;
            if (iss_s2.last && odd_q) begin
                beat_nx.fv_data = {{HALF_BW{1'b0}}, q[HALF_BW-1:0]}; // Odd N pad
            end else begin
                beat_nx.fv_data = q;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            sram_cmd <= '{cen: 1'b1, wen: 1'b1, default: '0};
            iss_s1   <= '0;
            iss_s2   <= '0;
            rd_left  <= '0;
            beat_out <= '0;
            done     <= 1'b0;
        end else begin
            state    <= state_nx;
            sram_cmd <= cmd_nx;
            iss_s1   <= iss_nx;
            iss_s2   <= iss_s1;
            rd_left  <= rd_left_nx;
            beat_out <= beat_nx;
            done     <= beat_out.valid && beat_out.eos;
        end
    end

    // Request fields kept for the whole stream
    always_ff @(posedge clk) begin
        if (start_rd) begin
            tag_q <= pend_req.pe_tag;
            odd_q <= pend_req.num_fv[0];
        end
    end

    assign busy = (state != st_idle) || iss_s1.valid || iss_s2.valid || beat_out.valid;

endmodule

`default_nettype wire

// ==== fv_bank_top.sv ====
// Feature-vector bank top level with request port, controller and SRAM
`timescale 1ns/100ps
`default_nettype none

module fv_bank_top
    import fv_mem_pkg::*, fv_pe_pkg::*;
#(
    parameter int SRAM_DEPTH = 1024
) (
    input  logic     clk,
    input  logic     reset,
    input  fv_load_t load_in,
    input  rd_req_t  rd_req,
    input  logic     req,
    output logic     ack,
    output pe_beat_t beat_out,
    output logic     busy
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wires
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic             pend_valid;
    rd_req_t          pend_req;
    logic             done;
    sram_cmd_t        sram_cmd;
    logic [FV_BW-1:0] q;

    fv_req_port req_port_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .rd_req     (rd_req),
        .done       (done),
        .ack        (ack),
        .pend_valid (pend_valid),
        .pend_req   (pend_req)
    );

    fv_bank_ctrl bank_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .load_in    (load_in),
        .pend_valid (pend_valid),
        .pend_req   (pend_req),
        .q          (q),
        .sram_cmd   (sram_cmd),
        .beat_out   (beat_out),
        .done       (done),
        .busy       (busy)
    );

    fv_sram #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) sram_i (
        .clk (clk),
        .cmd (sram_cmd),
        .q   (q)
    );

endmodule

`default_nettype wire

// ==== fv_mem_pkg.sv ====
// Memory-side widths, SRAM command struct, load-stream struct and controller states
`default_nettype none

package fv_mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int FV_BW  = 16;            // Bank word, two 8-bit features
    localparam int ADDR_W = 10;            // Bank address

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM port and load stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic              cen;            // Chip enable, low active
        logic              wen;            // Write enable, low active
        logic [ADDR_W-1:0] a;
        logic [FV_BW-1:0]  d;
    } sram_cmd_t;

    typedef struct packed {
        logic              sos;            // First word of a load
        logic              eos;            // Last word of a load
        logic [ADDR_W-1:0] a;
        logic [FV_BW-1:0]  fv_data;
    } fv_load_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bank controller states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_stream = 2'd1,                  // Reading and formatting beats
        st_load   = 2'd2                   // Writing a load stream
    } bank_state_t;

endpackage

`default_nettype wire

// ==== fv_pe_pkg.sv ====
// Edge-PE side widths, read-request struct and PE beat struct
`default_nettype none

package fv_pe_pkg;

    import fv_mem_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int TAG_W = 2;              // Four edge PEs
    localparam int NUM_W = 6;              // Feature count, 1 to 63

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and beat formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [ADDR_W-1:0] addr;           // First bank word of the vector
        logic [NUM_W-1:0]  num_fv;         // Number of 8-bit features
        logic [TAG_W-1:0]  pe_tag;
    } rd_req_t;

    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        logic [TAG_W-1:0]  pe_tag;
        logic [FV_BW-1:0]  fv_data;        // Low byte is the earlier feature
    } pe_beat_t;

endpackage

`default_nettype wire

// ==== fv_req_port.sv ====
// Four-phase req/ack front end holding one pending read request
`timescale 1ns/100ps
`default_nettype none

module fv_req_port
    import fv_pe_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    req,
    input  rd_req_t rd_req,
    input  logic    done,
    output logic    ack,
    output logic    pend_valid,
    output rd_req_t pend_req
);

    typedef enum logic [1:0] {
        rp_wait = 2'd0,                    // No request outstanding
        rp_pend = 2'd1,                    // Request handed to controller
        rp_ack  = 2'd2                     // Holding ack until req drops
    } port_state_t;

    port_state_t state;
    port_state_t state_nx;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nx = state;
        case (state)
            rp_wait: if (req) state_nx = rp_pend;
            rp_pend: if (done) state_nx = rp_ack;
            rp_ack:  if (!req) state_nx = rp_wait;
            default: state_nx = rp_wait;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rp_wait;
        end else begin
            state <= state_nx;
        end
    end

    // Capture once so the requester may move on after ack
    always_ff @(posedge clk) begin
        if (state == rp_wait && req) begin
            pend_req <= rd_req;
        end
    end

    assign pend_valid = (state == rp_pend);
    assign ack        = (state == rp_ack);

endmodule

`default_nettype wire

// ==== fv_sram.sv ====
// Behavioral single-port bank SRAM, active-low enables, one-cycle read latency
`timescale 1ns/100ps
`default_nettype none

module fv_sram
    import fv_mem_pkg::*;
#(
    parameter int SRAM_DEPTH = 1024
) (
    input  logic             clk,
    input  sram_cmd_t        cmd,
    output logic [FV_BW-1:0] q
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [FV_BW-1:0] mem [SRAM_DEPTH];

    logic do_write;
    logic do_read;

    assign do_write = !cmd.cen && !cmd.wen;
    assign do_read  = !cmd.cen && cmd.wen;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[cmd.a] <= cmd.d;
        end
    end

    // Output register holds between reads
    always_ff @(posedge clk) begin
        if (do_read) begin
            q <= mem[cmd.a];
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
fv_mem_pkg.sv
fv_pe_pkg.sv
fv_sram.sv
fv_req_port.sv
fv_bank_ctrl.sv
fv_bank_top.sv
tb_fv_bank.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the feature-vector bank testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_fv_bank -o tb_fv_bank
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fv_bank > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

// ==== tb_fv_bank.sv ====
// Testbench for the feature-vector bank with reference model, beat checker and assertions
`timescale 1ns/100ps
`default_nettype none

module tb_fv_bank
    import fv_mem_pkg::*, fv_pe_pkg::*;
;

    localparam int SRAM_DEPTH = 1024;
    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY    = 2;
    localparam int RESET_CYC  = 8;
    localparam int N_DIR_RD   = 14;                 // Directed reads over all tests
    localparam int N_RAND     = 16;
    localparam int RD_CYC_MAX = 64;                 // Longest read plus a queued load
    localparam int LD_LEN_MAX = 24;
    localparam int WD_CYCLES  = RESET_CYC + 40 + (SRAM_DEPTH + 4)
                              + (N_DIR_RD + N_RAND) * RD_CYC_MAX
                              + (N_RAND + 1) * (LD_LEN_MAX + 4) + 500;

    logic     clk = 1'b0;
    logic     reset;
    fv_load_t load_in;
    rd_req_t  rd_req;
    logic     req;
    logic     ack;
    pe_beat_t beat_out;
    logic     busy;

    logic [FV_BW-1:0] ref_mem [SRAM_DEPTH];         // Mirror of every load word
    pe_beat_t         exp_q [$];
    pe_beat_t         exp_beat;
    logic             in_stream = 1'b0;
    integer           seed = 32'hfffd7d39;
    int               errors = 0;
    int               err_at_start;
    int               tests_run = 0;
    int               tests_failed = 0;
    string            test_name;

    fv_bank_top #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) dut_i (
        .clk      (clk),
        .reset    (reset),
        .load_in  (load_in),
        .rd_req   (rd_req),
        .req      (req),
        .ack      (ack),
        .beat_out (beat_out),
        .busy     (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assert property (@(posedge clk) disable iff (reset) beat_out.valid |-> busy)
        else begin $display("[ERROR] busy = 0x%h during a beat", busy); errors++; end
    assert property (@(posedge clk) disable iff (reset) beat_out.valid |-> !ack)
        else begin $display("[ERROR] ack = 0x%h during a beat", ack); errors++; end
    assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
        else begin $display("[ERROR] ack = 0x%h dropped while req was high", ack); errors++; end
    assert property (@(posedge clk) disable iff (reset) ack && !req |=> !ack)
        else begin $display("[ERROR] ack = 0x%h held after req fell", ack); errors++; end
    assert property (@(posedge clk) disable iff (reset)
                     $rose(ack) |-> $past(beat_out.valid && beat_out.eos, 2))
        else begin $display("Ack rose without an eos beat two cycles before"); errors++; end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!reset && beat_out.valid) begin
            if (exp_q.size() == 0) begin
                $display("Beat with no read outstanding, data 0x%h", beat_out.fv_data);
                errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                assert (beat_out.fv_data == exp_beat.fv_data) else begin
                    $display("[ERROR] beat_out.fv_data expected 0x%h got 0x%h",
                             exp_beat.fv_data, beat_out.fv_data);
                    errors++;
                end
                assert ({beat_out.sos, beat_out.eos} == {exp_beat.sos, exp_beat.eos}) else begin
                    $display("[ERROR] beat_out.sos/eos expected 0x%h got 0x%h",
                             {exp_beat.sos, exp_beat.eos}, {beat_out.sos, beat_out.eos});
                    errors++;
                end
                assert (beat_out.pe_tag == exp_beat.pe_tag) else begin
                    $display("[ERROR] beat_out.pe_tag expected 0x%h got 0x%h",
                             exp_beat.pe_tag, beat_out.pe_tag);
                    errors++;
                end
                in_stream = !exp_beat.eos;
            end
        end else if (!reset && in_stream) begin
            $display("Gap in beat stream before the eos beat");  // Beats must be back to back
            errors++;
            in_stream = 1'b0;
        end
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [FV_BW-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return FV_BW'(a) * 16'h0025 ^ 16'h6b1d;       // Odd multiplier keeps words distinct
    endfunction

    task automatic step();
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - err_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    task automatic load_vector(input logic [ADDR_W-1:0] addr, input int len, input bit pattern);
        int               i;
        logic [ADDR_W-1:0] a;
        logic [FV_BW-1:0]  w;
        while (busy) step();                          // Loads have no handshake
        for (i = 0; i < len; i++) begin
            a          = ADDR_W'(addr + i);
            w          = pattern ? fill_word(a) : FV_BW'($random(seed));
            ref_mem[a] = w;
            load_in    = '{sos: (i == 0), eos: (i == len - 1), a: a, fv_data: w};
            step();
        end
        load_in = '0;
    endtask

    task automatic read_vector(input logic [ADDR_W-1:0] addr, input int num,
                               input logic [TAG_W-1:0] tag);
        int               nb;
        int               k;
        int               waited;
        logic [FV_BW-1:0] w;
        nb = (num + 1) / 2;
        for (k = 0; k < nb; k++) begin
            w = ref_mem[ADDR_W'(addr + k)];
            if (k == nb - 1 && num % 2 == 1) w[FV_BW-1:FV_BW/2] = '0;  // Odd N pad
            exp_q.push_back('{valid: 1'b1, sos: (k == 0), eos: (k == nb - 1),
                              pe_tag: tag, fv_data: w});
        end
        rd_req = '{addr: addr, num_fv: NUM_W'(num), pe_tag: tag};
        req    = 1'b1;
        waited = 0;
        while (!ack && waited < RD_CYC_MAX) begin
            step();
            waited++;
        end
        if (!ack) begin
            $display("Read of %0d features at 0x%h got no ack", num, addr);
            errors++;
            exp_q.delete();
        end else begin
            assert (exp_q.size() == 0) else begin
                $display("[ERROR] beats left at ack expected 0x0 got 0x%h", exp_q.size());
                errors++;
                exp_q.delete();
            end
            repeat (2) step();                        // Ack must hold while req stays high
        end
        rd_req = rd_req_t'($random(seed));            // Request was latched, bus is free
        req    = 1'b0;
        waited = 0;
        while (ack && waited < 4) begin
            step();
            waited++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int i;
        reset   = 1'b1;
        req     = 1'b0;
        rd_req  = '0;
        load_in = '0;
        repeat (RESET_CYC) @(posedge clk);
        #DRV_DLY;
        reset = 1'b0;

        begin_test("reset_idle");
        for (i = 0; i < 16; i++) begin
            assert (!beat_out.valid && !ack && !busy) else begin
                $display("[ERROR] valid/ack/busy expected 0x0 got 0x%h",
                         {beat_out.valid, ack, busy});
                errors++;
            end
            step();
        end
        load_vector('0, SRAM_DEPTH, 1'b1);            // Whole bank in one stream
        end_test();

        begin_test("even_count");
        read_vector(10'h010, 2, 2'd0);
        read_vector(10'h3fe, 6, 2'd1);                // Wraps past the top
        read_vector(10'h123, 10, 2'd2);
        read_vector(10'h200, 62, 2'd3);
        end_test();

        begin_test("odd_count");
        read_vector(10'h005, 1, 2'd1);
        read_vector(10'h077, 3, 2'd2);
        read_vector(10'h181, 17, 2'd3);
        read_vector(10'h3f0, 63, 2'd0);
        end_test();

        begin_test("tags_handshake");
        for (i = 0; i < 4; i++) begin
            read_vector(ADDR_W'(10'h2a0 + 40 * i), 5 + 4 * i, TAG_W'(i));
        end
        fork
            read_vector(10'h050, 20, 2'd2);
            begin
                step();                               // Same idle cycle as pend_valid
                load_vector(10'h300, 8, 1'b0);
            end
        join
        read_vector(10'h300, 16, 2'd1);
        end_test();

        begin_test("random_mix");
        for (i = 0; i < N_RAND; i++) begin
            if ($random(seed) & 1) begin
                load_vector(ADDR_W'($random(seed)), 1 + $unsigned($random(seed)) % LD_LEN_MAX,
                            1'b0);
            end
            read_vector(ADDR_W'($random(seed)), 1 + $unsigned($random(seed)) % 63,
                        TAG_W'($random(seed)));
        end
        repeat (4) step();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
